//--- i2c_defs.svh
//##############################
// I2C timing and sizes
//##############################
`ifndef I2C_DEFS_SVH
`define I2C_DEFS_SVH

// Bus timing in clock counts, 50 MHz system clock
`define I2C_THD_STA       225   // START hold, 4.5 us
`define I2C_TLOW          250   // SCL low period, 5 us
`define I2C_THIGH         225   // SCL high period, 4.5 us
`define I2C_TSU_DAT       100   // SDA set up this many counts before SCL rises
`define I2C_TSU_STO       225   // SDA rises this far into the STOP high phase
`define I2C_THIGH_SAMPLE  50    // SDA sample point after SCL rises

// Phase counter must hold the largest count above
`define I2C_CNT_W         10

// Byte count fields, 2 bits so 1 to 3 bytes per transfer
`define I2C_BYTES_LOG     2

// Data word for 3 bytes
`define I2C_DATA_W        24

`endif

//--- i2c_bus_pkg.sv
//##############################
// Bus line types
//##############################
package i2c_bus_pkg;

  // Bus monitor FSM
  typedef enum logic [1:0] {
    bus_free       = 2'd0,  // No transfer on the lines
    bus_start_seen = 2'd1,  // SDA fell with SCL high
    bus_busy_low   = 2'd2,  // Transfer running, SCL low or data 1
    bus_busy_high  = 2'd3   // SCL high with SDA low, STOP may follow
  } bus_state_t;

  // SCL generator phase
  typedef enum logic [1:0] {
    ph_hold = 2'd0,  // SCL released, START hold
    ph_low  = 2'd1,  // SCL driven low
    ph_high = 2'd2   // SCL released
  } scl_phase_t;

endpackage

//--- i2c_ctrl_pkg.sv
//##############################
// Transfer types
//##############################
package i2c_ctrl_pkg;

  // Transfer FSM
  typedef enum logic [3:0] {
    st_idle      = 4'd0,  // Waiting for a request on a free bus
    st_initiate  = 4'd1,  // START hold with SDA low
    st_addr_bit  = 4'd2,  // Address and R/W bits
    st_addr_ack  = 4'd3,  // Target ACK for the address
    st_data_bit  = 4'd4,  // Data bits, either direction
    st_data_ack  = 4'd5,  // ACK slot after a data byte
    st_stop_low  = 4'd6,  // Pull SDA low while SCL is low
    st_stop_high = 4'd7   // Release SDA during SCL high
  } ctrl_state_t;

  // Transfer direction, same coding as the R/W bit
  typedef enum logic {
    dir_write = 1'b0,
    dir_read  = 1'b1
  } dir_t;

endpackage

//--- i2c_bus_monitor.sv
//##############################
// Bus START/STOP monitor
//##############################
`timescale 1ns/1ns
`include "i2c_defs.svh"

module i2c_bus_monitor
  import i2c_bus_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic scl_in,   // Wired-AND SCL
  input  logic sda_in,   // Wired-AND SDA
  output logic bus_busy  // High between START and STOP
);

  bus_state_t state;
  bus_state_t next_state;

  always_comb begin
    next_state = state;
    case (state)
      bus_free:       if (scl_in && !sda_in) next_state = bus_start_seen;  // SDA fell, SCL high
      bus_start_seen: begin
        if (!scl_in && !sda_in)
          next_state = bus_busy_low;  // First SCL low closes the START
        else if (scl_in && sda_in)
          next_state = bus_free;      // SDA came back, no START after all
      end
      bus_busy_low:   if (scl_in && !sda_in) next_state = bus_busy_high;
      bus_busy_high: begin
        if (scl_in && sda_in)
          next_state = bus_free;      // STOP
        else if (!scl_in)
          next_state = bus_busy_low;
      end
      default:        next_state = bus_free;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst)
      state <= bus_free;
    else
      state <= next_state;
  end

  assign bus_busy = (state != bus_free);  // Busy from the START on

  // A START needs SCL high, so busy never begins during a low phase
  a_busy_scl_high: assert property (@(posedge clk) disable iff (!rst)
    $rose(bus_busy) |-> $past(scl_in));

endmodule

//--- i2c_bit_timer.sv
//##############################
// SCL phase timer
//##############################
`timescale 1ns/1ns
`include "i2c_defs.svh"

module i2c_bit_timer
  import i2c_bus_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic hold_run,    // START hold requested
  input  logic bit_run,     // Bit clocking requested
  output logic scl_out,     // 1 releases the line
  output logic hold_done,   // Last START hold count
  output logic drive_evt,   // SDA may change now
  output logic sample_evt,  // SDA sample point
  output logic stop_evt,    // SDA rise for STOP
  output logic bit_done     // Last high cycle of a bit
);

  scl_phase_t            phase;
  logic [`I2C_CNT_W-1:0] cnt;
  logic                  in_low;
  logic                  in_high;

  assign in_low  = bit_run && (phase == ph_low);
  assign in_high = bit_run && (phase == ph_high);

  // SCL is pulled only during the low phase of a running bit
  assign scl_out = !in_low;

  assign hold_done  = hold_run && (phase == ph_hold) &&
                      (cnt == `I2C_CNT_W'(`I2C_THD_STA));
  assign drive_evt  = in_low && (cnt == `I2C_CNT_W'(`I2C_TLOW - `I2C_TSU_DAT));
  assign sample_evt = in_high && (cnt == `I2C_CNT_W'(`I2C_THIGH_SAMPLE));
  assign stop_evt   = in_high && (cnt == `I2C_CNT_W'(`I2C_TSU_STO));
  assign bit_done   = in_high && (cnt == `I2C_CNT_W'(`I2C_THIGH));

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      phase <= ph_hold;
      cnt   <= '0;
    end else if (bit_run) begin
      case (phase)
        ph_low: begin
          if (cnt == `I2C_CNT_W'(`I2C_TLOW)) begin  // TLOW+1 cycles low
            phase <= ph_high;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ph_high: begin
          if (bit_done) begin  // Next bit starts low
            phase <= ph_low;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          phase <= ph_low;
          cnt   <= '0;
        end
      endcase
    end else if (hold_run) begin
      if (hold_done) begin
        phase <= ph_low;  // bit_run takes over on the next cycle
        cnt   <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end else begin
      phase <= ph_hold;  // Idle, SCL released
      cnt   <= '0;
    end
  end

  // stop_evt may share the last high cycle with bit_done
  a_one_strobe: assert property (@(posedge clk) disable iff (!rst)
    $onehot0({hold_done, drive_evt, sample_evt, bit_done}));

endmodule

//--- i2c_shift_unit.sv
//##############################
// Address and data shifter
//##############################
`timescale 1ns/1ns
`include "i2c_defs.svh"

module i2c_shift_unit
  import i2c_ctrl_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      load,               // Capture request fields
  input  logic [7:0]                addr_target,        // Address, R/W in bit 0
  input  logic [`I2C_DATA_W-1:0]    data_send,
  input  logic [`I2C_BYTES_LOG-1:0] num_bytes_send,
  input  logic                      shift_tx,           // Advance to next TX bit
  input  logic                      shift_rx,           // Capture SDA
  input  logic                      sda_in,
  output logic                      tx_bit,             // Bit to put on SDA
  output logic                      byte_full,          // Eight bits moved
  output logic [`I2C_DATA_W-1:0]    data_received
);

  logic [`I2C_DATA_W+7:0]    tx_reg;    // Address on top, data below
  logic [`I2C_DATA_W-1:0]    tx_data;
  logic [`I2C_BYTES_LOG+2:0] pad_bits;  // Unused byte slots, in bits
  logic [3:0]                bit_cnt;

  // Move the selected low bytes up against the address
  assign pad_bits = {{`I2C_BYTES_LOG{1'b1}} - num_bytes_send, 3'b000};
  assign tx_data  = (dir_t'(addr_target[0]) == dir_write) ? (data_send << pad_bits) : '0;

  assign tx_bit    = tx_reg[`I2C_DATA_W+7];  // MSB first
  assign byte_full = (bit_cnt == 4'd8);

  always_ff @(posedge clk) begin
    if (load)
      tx_reg <= {addr_target, tx_data};
    else if (shift_tx)
      tx_reg <= {tx_reg[`I2C_DATA_W+6:0], 1'b0};
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      bit_cnt       <= '0;
      data_received <= '0;
    end else if (load) begin
      bit_cnt       <= '0;
      data_received <= '0;  // Fresh result per transfer
    end else if (shift_tx || shift_rx) begin
      if (byte_full) begin
        bit_cnt <= '0;  // Ninth strobe is the ACK slot, nothing moves
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
        if (shift_rx)
          data_received <= {data_received[`I2C_DATA_W-2:0], sda_in};  // Last byte ends lowest
      end
    end
  end

endmodule

//--- i2c_byte_ctrl.sv
//##############################
// I2C transfer controller
//##############################
`timescale 1ns/1ns
`include "i2c_defs.svh"

module i2c_byte_ctrl
  import i2c_ctrl_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,              // Request level
  input  logic                      addr_rw,            // 1 reads
  input  logic [`I2C_BYTES_LOG-1:0] num_bytes_send,
  input  logic [`I2C_BYTES_LOG-1:0] num_bytes_receive,
  input  logic                      bus_busy,
  input  logic                      sda_in,
  input  logic                      hold_done,
  input  logic                      drive_evt,
  input  logic                      sample_evt,
  input  logic                      stop_evt,
  input  logic                      bit_done,
  input  logic                      tx_bit,
  input  logic                      byte_full,
  output logic                      hold_run,
  output logic                      bit_run,
  output logic                      load,
  output logic                      shift_tx,
  output logic                      shift_rx,
  output logic                      sda_out,            // 1 releases the line
  output logic                      done,
  output logic                      ack_error
);

  ctrl_state_t               state;
  dir_t                      dir_q;
  logic [`I2C_BYTES_LOG-1:0] num_q;     // Byte count for the active direction
  logic [`I2C_BYTES_LOG-1:0] byte_cnt;  // Data bytes completed
  logic                      last_byte;

  assign last_byte = (byte_cnt == num_q);

  // Shifter strobes, the shifter acts on the following edge
  assign shift_tx = drive_evt && ((state == st_addr_bit) ||
                    ((state == st_data_bit) && (dir_q == dir_write)));
  assign shift_rx = sample_evt && ((state == st_addr_ack) || (state == st_data_ack) ||
                    ((state == st_data_bit) && (dir_q == dir_read)));

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state     <= st_idle;
      dir_q     <= dir_write;
      num_q     <= '0;
      byte_cnt  <= '0;
      hold_run  <= 1'b0;
      bit_run   <= 1'b0;
      load      <= 1'b0;
      sda_out   <= 1'b1;
      done      <= 1'b0;
      ack_error <= 1'b0;
    end else begin
      load <= 1'b0;
      done <= 1'b0;
      case (state)
        st_idle: begin
          if (start && !bus_busy) begin  // Only on a free bus
            state     <= st_initiate;
            hold_run  <= 1'b1;
            load      <= 1'b1;
            sda_out   <= 1'b0;  // START, SCL still high
            ack_error <= 1'b0;
            byte_cnt  <= '0;
          end
        end
        st_initiate: begin
          if (load) begin  // Same cycle the shifter captures
            dir_q <= dir_t'(addr_rw);
            num_q <= addr_rw ? num_bytes_receive : num_bytes_send;
          end
          if (hold_done) begin
            state    <= st_addr_bit;
            hold_run <= 1'b0;
            bit_run  <= 1'b1;
          end
        end
        st_addr_bit: begin
          if (drive_evt)
            sda_out <= tx_bit;
          if (bit_done && byte_full)
            state <= st_addr_ack;
        end
        st_addr_ack: begin
          if (drive_evt)
            sda_out <= 1'b1;  // Let the target answer
          if (sample_evt && sda_in)
            ack_error <= 1'b1;  // Address NACK
          if (bit_done)
            state <= ack_error ? st_stop_low : st_data_bit;
        end
        st_data_bit: begin
          if (drive_evt)
            sda_out <= (dir_q == dir_write) ? tx_bit : 1'b1;  // Released on reads
          if (bit_done && byte_full) begin
            state    <= st_data_ack;
            byte_cnt <= byte_cnt + 1'b1;
          end
        end
        st_data_ack: begin
          // Write: release for target ACK. Read: ACK, or NACK on the final byte
          if (drive_evt)
            sda_out <= (dir_q == dir_write) || last_byte;
          if (sample_evt && (dir_q == dir_write) && sda_in)
            ack_error <= 1'b1;
          if (bit_done)
            state <= (ack_error || last_byte) ? st_stop_low : st_data_bit;
        end
        st_stop_low: begin
          if (drive_evt) begin
            sda_out <= 1'b0;  // SDA low ahead of the STOP edge
            state   <= st_stop_high;
          end
        end
        st_stop_high: begin
          if (stop_evt)
            sda_out <= 1'b1;  // STOP
          if (bit_done) begin
            state   <= st_idle;
            bit_run <= 1'b0;
            done    <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Timer must be stopped whenever no transfer is active
  a_idle_no_clock: assert property (@(posedge clk) disable iff (!rst)
    (state == st_idle) |-> !bit_run);

endmodule

//--- i2c_master.sv
//##############################
// I2C master top
//##############################
`timescale 1ns/1ns
`include "i2c_defs.svh"

module i2c_master (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  logic [7:0]                addr_target,        // Bit 0 is R/W
  input  logic [`I2C_DATA_W-1:0]    data_send,
  input  logic [`I2C_BYTES_LOG-1:0] num_bytes_send,
  input  logic [`I2C_BYTES_LOG-1:0] num_bytes_receive,
  output logic                      scl_out,
  output logic                      sda_out,
  input  logic                      scl_in,
  input  logic                      sda_in,
  output logic [`I2C_DATA_W-1:0]    data_received,
  output logic                      bus_busy,
  output logic                      done,
  output logic                      ack_error
);

  logic hold_run;
  logic bit_run;
  logic hold_done;
  logic drive_evt;
  logic sample_evt;
  logic stop_evt;
  logic bit_done;
  logic load;
  logic shift_tx;
  logic shift_rx;
  logic tx_bit;
  logic byte_full;

  i2c_bus_monitor i_mon (.clk, .rst, .scl_in, .sda_in, .bus_busy);

  i2c_bit_timer i_timer (.clk, .rst, .hold_run, .bit_run, .scl_out, .hold_done, .drive_evt,
                         .sample_evt, .stop_evt, .bit_done);

  i2c_shift_unit i_shift (.clk, .rst, .load, .addr_target, .data_send, .num_bytes_send,
                          .shift_tx, .shift_rx, .sda_in, .tx_bit, .byte_full, .data_received);

  i2c_byte_ctrl i_ctrl (.clk, .rst, .start, .addr_rw(addr_target[0]), .num_bytes_send,
                        .num_bytes_receive, .bus_busy, .sda_in, .hold_done, .drive_evt,
                        .sample_evt, .stop_evt, .bit_done, .tx_bit, .byte_full, .hold_run,
                        .bit_run, .load, .shift_tx, .shift_rx, .sda_out, .done, .ack_error);

endmodule

//--- tb_i2c_target.sv
//##############################
// I2C target model
//##############################
`timescale 1ns/1ns
`include "i2c_defs.svh"

module tb_i2c_target (
  input  logic                   scl,
  input  logic                   sda,
  input  logic                   ack_addr,   // 1 answers the address with ACK
  input  logic                   ack_data,   // 1 answers written bytes with ACK
  input  logic [`I2C_DATA_W-1:0] read_data,  // First byte sent sits on top
  input  logic                   foreign,    // Rise fakes a foreign START, fall its STOP
  output logic                   scl_drv,    // 1 releases
  output logic                   sda_drv,
  output logic [31:0]            rx_bytes,   // Address and written bytes, newest lowest
  output int                     rx_cnt,
  output int                     rises,      // SCL rising edges since START
  output logic [3:0]             mack_log,   // Master ACK bits on reads, newest lowest
  output int                     starts,
  output int                     stops
);

  logic [7:0]             sr_in;
  logic [`I2C_DATA_W-1:0] tx_sr;
  logic                   bit_sda;
  logic                   fsda;
  logic                   fscl;
  logic                   active;     // Between START and STOP
  logic                   reading;
  logic                   nack_seen;
  int                     bit_idx;    // 8 is the ACK slot
  int                     byte_idx;   // 0 is the address

  assign scl_drv = fscl;
  assign sda_drv = bit_sda & fsda;

  initial begin
    bit_sda = 1'b1;
    fsda    = 1'b1;
    fscl    = 1'b1;
    active  = 1'b0;
    starts  = 0;
    stops   = 0;
  end

  // START, SDA falls with SCL high
  always @(negedge sda) begin
    if (scl) begin
      starts++;
      active    = 1'b1;
      bit_idx   = 0;
      byte_idx  = 0;
      rx_cnt    = 0;
      rises     = 0;
      rx_bytes  = '0;
      mack_log  = '0;
      reading   = 1'b0;
      nack_seen = 1'b0;
      bit_sda   = 1'b1;
    end
  end

  always @(posedge sda) begin
    if (scl) begin  // STOP
      stops++;
      active  = 1'b0;
      bit_sda = 1'b1;
    end
  end

  // Capture on the rising SCL edge
  always @(posedge scl) begin
    if (active) begin
      rises++;
      if (bit_idx < 8) begin
        sr_in = {sr_in[6:0], sda};
        bit_idx++;
        if (bit_idx == 8 && byte_idx == 0) begin
          reading = sr_in[0];  // R/W bit
          tx_sr   = read_data;
        end
        if (bit_idx == 8 && (byte_idx == 0 || !reading)) begin
          rx_bytes = {rx_bytes[23:0], sr_in};
          rx_cnt++;
        end
      end else begin
        if (reading && byte_idx > 0) begin
          mack_log  = {mack_log[2:0], sda};  // 0 ACK, 1 NACK
          nack_seen = sda;
        end
        bit_idx = 0;
        byte_idx++;
      end
    end
  end

  // SDA changes only while SCL is low
  always @(negedge scl) begin
    if (active) begin
      if (bit_idx == 8)
        bit_sda = (byte_idx == 0) ? !ack_addr : (reading || !ack_data);
      else if (reading && byte_idx > 0 && !nack_seen) begin
        bit_sda = tx_sr[`I2C_DATA_W-1];
        tx_sr   = tx_sr << 1;
      end else
        bit_sda = 1'b1;
    end
  end

  always @(posedge foreign) begin
    fsda = 1'b0;  // Foreign START
    #200;
    fscl = 1'b0;  // Then hold SCL low, bus busy
  end

  always @(negedge foreign) begin
    fscl = 1'b1;
    #200;
    fsda = 1'b1;  // Foreign STOP
  end

endmodule

//--- tb_i2c_master.sv
//##############################
// I2C master testbench
//##############################
`timescale 1ns/1ns
`include "i2c_defs.svh"

module tb_i2c_master;

  localparam int bit_cycles      = `I2C_TLOW + `I2C_THIGH + 2;
  // START hold, address, 3 bytes, STOP bit
  localparam int xfer_cycles     = `I2C_THD_STA + 1 + (4 * 9 + 1) * bit_cycles;
  localparam int num_tests       = 5;
  localparam int watchdog_cycles = xfer_cycles * num_tests + 20000;

  logic                      clk;
  logic                      rst;
  logic                      start;
  logic [7:0]                addr_target;
  logic [`I2C_DATA_W-1:0]    data_send;
  logic [`I2C_DATA_W-1:0]    data_received;
  logic [`I2C_BYTES_LOG-1:0] num_bytes_send;
  logic [`I2C_BYTES_LOG-1:0] num_bytes_receive;
  logic                      scl_out, sda_out, scl_in, sda_in;
  logic                      bus_busy, done, ack_error;
  logic                      t_scl, t_sda, ack_addr, ack_data, foreign;
  logic [`I2C_DATA_W-1:0]    read_data;
  logic [31:0]               rx_bytes;
  logic [3:0]                mack_log;
  int                        rx_cnt, rises, starts, stops;
  int                        done_cnt = 0;
  int                        errors = 0;
  int                        test_errors = 0;
  int                        tests_run = 0;
  int                        tests_failed = 0;
  logic [31:0]               rng;
  string                     cur_test;

  assign scl_in = scl_out & t_scl;  // Wired-AND bus
  assign sda_in = sda_out & t_sda;

  i2c_master i_dut (.*);

  tb_i2c_target i_target (.scl(scl_in), .sda(sda_in), .ack_addr, .ack_data, .read_data,
                          .foreign, .scl_drv(t_scl), .sda_drv(t_sda), .rx_bytes, .rx_cnt,
                          .rises, .mack_log, .starts, .stops);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(negedge clk) if (done) done_cnt++;

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
    assert (exp === got) else begin
      $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, got);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    assert (cond) else begin
      $display("Error in %s: %s", cur_test, msg);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = errors;
    tests_run++;
  endtask

  task automatic end_test;
    if (errors == test_errors)
      $display("%s: ok", cur_test);
    else begin
      tests_failed++;
      $display("%s: %0d errors", cur_test, errors - test_errors);
    end
  endtask

  task automatic set_request(input logic [7:0] addr, input logic [23:0] data,
                             input logic [1:0] n_send, input logic [1:0] n_recv);
    @(negedge clk);
    addr_target       = addr;
    data_send         = data;
    num_bytes_send    = n_send;
    num_bytes_receive = n_recv;
    start             = 1'b1;
  endtask

  // Acceptance shows as the START, SDA pulled with SCL released
  task automatic wait_accept(input int limit);
    int n;
    n = 0;
    while (sda_out && n < limit) begin
      @(negedge clk);
      n++;
    end
    check_true(!sda_out, "request was never accepted");
    start = 1'b0;  // Dropped well before done
  endtask

  task automatic wait_done(output bit busy_seen);
    int n;
    bit seen;
    n         = 0;
    seen      = 1'b0;
    busy_seen = 1'b0;
    while (!seen && n < xfer_cycles + 1000) begin
      @(negedge clk);
      busy_seen |= bus_busy;
      seen = done;
      n++;
    end
    check_true(seen, "timed out waiting for done");
    repeat (4) @(negedge clk);  // STOP reaches the monitor
  endtask

  task automatic test_reset;
    begin_test("reset_state");
    check_value("scl_out", 1, scl_out);
    check_value("sda_out", 1, sda_out);
    check_value("done", 0, done);
    check_value("ack_error", 0, ack_error);
    check_value("bus_busy", 0, bus_busy);
    end_test;
  endtask

  task automatic test_write_two;
    int  d0;
    int  s0;
    bit  busy_seen;
    begin_test("write_two_bytes");
    d0 = done_cnt;
    s0 = stops;
    set_request({7'h52, 1'b0}, 24'h3c_a5_96, 2'd2, 2'd0);
    wait_accept(10);
    wait_done(busy_seen);
    check_value("bytes on bus", 3, rx_cnt);
    check_value("bus data", {8'ha4, 8'ha5, 8'h96}, rx_bytes[23:0]);  // Low two bytes only
    check_value("scl pulses", 3 * 9 + 1, rises);
    check_value("stops", 1, stops - s0);
    check_value("done pulses", 1, done_cnt - d0);
    check_value("ack_error", 0, ack_error);
    check_true(busy_seen, "bus_busy never rose during the transfer");
    check_value("bus_busy after", 0, bus_busy);
    end_test;
  endtask

  task automatic test_read_three;
    int         d0;
    bit         busy_seen;
    logic [7:0] b0, b1, b2;
    begin_test("read_three_bytes");
    rng = next_random(rng);
    b0  = rng[7:0];
    rng = next_random(rng);
    b1  = rng[7:0];
    rng = next_random(rng);
    b2  = rng[7:0];
    read_data = {b0, b1, b2};  // Model sends the top byte first
    d0 = done_cnt;
    set_request({7'h52, 1'b1}, 24'h0, 2'd0, 2'd3);
    wait_accept(10);
    wait_done(busy_seen);
    check_value("data_received", {b0, b1, b2}, data_received);  // Last byte lowest
    check_value("master acks", 3'b001, mack_log[2:0]);           // ACK, ACK, NACK
    check_value("address", 8'ha5, rx_bytes[7:0]);
    check_value("scl pulses", 4 * 9 + 1, rises);
    check_value("done pulses", 1, done_cnt - d0);
    check_value("ack_error", 0, ack_error);
    end_test;
  endtask

  task automatic test_addr_nack;
    int d0;
    int s0;
    bit busy_seen;
    begin_test("address_nack");
    ack_addr = 1'b0;
    d0 = done_cnt;
    s0 = stops;
    set_request({7'h1d, 1'b0}, 24'h00_00_ff, 2'd1, 2'd0);
    wait_accept(10);
    wait_done(busy_seen);
    check_value("bytes on bus", 1, rx_cnt);
    check_value("scl pulses", 9 + 1, rises);  // Address then straight to STOP
    check_value("stops", 1, stops - s0);
    check_value("done pulses", 1, done_cnt - d0);
    check_value("ack_error", 1, ack_error);
    ack_addr = 1'b1;
    end_test;
  endtask

  task automatic test_busy_defer;
    int n;
    int d0;
    int s0;
    bit held;
    bit busy_seen;
    begin_test("busy_deferral");
    @(negedge clk);
    foreign = 1'b1;
    n = 0;
    while (!bus_busy && n < 2) begin  // Monitor follows the START within a clock
      @(negedge clk);
      n++;
    end
    check_true(bus_busy, "bus_busy did not follow the foreign START within two cycles");
    set_request({7'h30, 1'b0}, 24'h00_00_c3, 2'd1, 2'd0);
    held = 1'b1;
    repeat (1000) begin
      @(negedge clk);
      if (!scl_out || !sda_out)
        held = 1'b0;
    end
    check_true(held, "master drove the bus while another master held it");
    d0 = done_cnt;
    s0 = stops;
    foreign = 1'b0;
    wait_accept(1000);
    check_value("foreign stop", 1, stops - s0);  // Accepted only after the bus freed
    wait_done(busy_seen);
    check_value("bytes on bus", 2, rx_cnt);
    check_value("bus data", {8'h60, 8'hc3}, rx_bytes[15:0]);
    check_value("scl pulses", 2 * 9 + 1, rises);
    check_value("done pulses", 1, done_cnt - d0);
    check_value("ack_error", 0, ack_error);
    check_value("bus_busy after", 0, bus_busy);
    end_test;
  endtask

  initial begin
    rst               = 1'b0;
    start             = 1'b0;
    addr_target       = '0;
    data_send         = '0;
    num_bytes_send    = '0;
    num_bytes_receive = '0;
    ack_addr          = 1'b1;
    ack_data          = 1'b1;
    read_data         = '0;
    foreign           = 1'b0;
    rng               = 32'hedd1_32e9;
    repeat (5) @(negedge clk);
    rst = 1'b1;
    @(negedge clk);
    test_reset;
    test_write_two;
    test_read_three;
    test_addr_nack;
    test_busy_defer;
    $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // Worst-case transfer per test plus margin for reset and the foreign hold
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run stopped", watchdog_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- list.f
+incdir+.
i2c_bus_pkg.sv
i2c_ctrl_pkg.sv
i2c_bus_monitor.sv
i2c_bit_timer.sv
i2c_shift_unit.sv
i2c_byte_ctrl.sv
i2c_master.sv
tb_i2c_target.sv
tb_i2c_master.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the I2C master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_i2c_master -f list.f \
  --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST RESULT: PASS" sim.log; then
  exit 0
fi
exit 1
